//--- Makefile
# Verilator build and run for the multi-cycle arithmetic unit

VERILATOR ?= verilator
FILELIST  ?= sources.f
TOP       ?= tbMcycle
RTL_TOP   ?= mcycleUnit
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
LINTFLAGS ?= --lint-only --timing -Wall
PASS_TEXT ?= Test OK

SIM_EXE = $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -Mdir $(BUILD_DIR) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./$(SIM_EXE))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

//--- hdl/mcycleArithPkg.sv
package mcycleArithPkg;

    //////////////////////////////
    // Widths
    //////////////////////////////

    // One processor word
    localparam int operandWidth = 32;

    // Upper half carries the partial sum or the partial remainder,
    // lower half the multiplier bits or the quotient bits
    localparam int accWidth = 2 * operandWidth;

    //////////////////////////////
    // Operation
    //////////////////////////////

    typedef enum logic {
        opMul = 1'b0,
        opDiv = 1'b1
    } mcycleOpT;

    //////////////////////////////
    // Request from the processor
    //////////////////////////////

    // Sampled only when a Start is accepted
    typedef struct packed {
        mcycleOpT                op;
        // Multiplicand or dividend
        logic [operandWidth-1:0] operand1;
        // Multiplier or divisor
        logic [operandWidth-1:0] operand2;
    } mcycleReqT;

endpackage

//--- hdl/mcycleControl.sv
`timescale 1ns/100ps

module mcycleControl (
    input  logic                    CLK,
    input  logic                    Reset,
    input  logic                    Start,
    input  logic                    StepDecision,
    output mcycleCtrlPkg::stepCtrlT Step,
    output logic                    Busy,
    output logic                    Done
);

    mcycleCtrlPkg::ctrlStateT state;
    mcycleCtrlPkg::ctrlStateT stateNext;

    logic [mcycleCtrlPkg::iterCountWidth-1:0] iterCnt;

    logic startAccept;
    logic lastIter;
    logic isRunning;

    //////////////////////////////
    // Start acceptance
    //////////////////////////////

    assign isRunning = (state == mcycleCtrlPkg::running);

    // Start is ignored while an operation is in flight
    assign startAccept = Start && !isRunning;

    // Counter sits at one during the final step
    assign lastIter = (iterCnt == mcycleCtrlPkg::iterCountWidth'(1));

    //////////////////////////////
    // State machine
    //////////////////////////////

    always_comb begin
        stateNext = state;
        unique case (state)
            mcycleCtrlPkg::idle,
            mcycleCtrlPkg::finish: begin
                if (startAccept) begin
                    stateNext = mcycleCtrlPkg::running;
                end else begin
                    stateNext = mcycleCtrlPkg::idle;
                end
            end
            mcycleCtrlPkg::running: begin
                if (lastIter) begin
                    stateNext = mcycleCtrlPkg::finish;
                end
            end
            default: begin
                stateNext = mcycleCtrlPkg::idle;
            end
        endcase
    end

    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            state <= mcycleCtrlPkg::idle;
        end else begin
            state <= stateNext;
        end
    end

    //////////////////////////////
    // Iteration counter
    //////////////////////////////

    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            iterCnt <= '0;
        end else if (startAccept) begin
            iterCnt <= mcycleCtrlPkg::iterCountWidth'(mcycleCtrlPkg::iterCount);
        end else if (isRunning) begin
            iterCnt <= iterCnt - 1'b1;
        end
    end

    //////////////////////////////
    // Outputs
    //////////////////////////////

    always_comb begin
        Step.init  = startAccept;
        Step.shift = isRunning;
        // Datapath tells us whether the adder result is kept
        Step.write = isRunning && StepDecision;
    end

    assign Busy = isRunning;
    assign Done = (state == mcycleCtrlPkg::finish);

    //////////////////////////////
    // Assertions
    //////////////////////////////

    doneSinglePulse: assert property (
        @(posedge CLK) disable iff (Reset)
        Done |=> !Done
    ) else $error("Done held high for two cycles");

    // A load is always followed by stepping, never by a second load
    initThenRun: assert property (
        @(posedge CLK) disable iff (Reset)
        Step.init |=> Step.shift && !Step.init
    ) else $error("Init seen while the operation is running");

    counterNoUnderflow: assert property (
        @(posedge CLK) disable iff (Reset)
        isRunning |-> (iterCnt != '0)
    ) else $error("Iteration counter underflow");

endmodule

//--- hdl/mcycleCtrlPkg.sv
package mcycleCtrlPkg;

    //////////////////////////////
    // Iteration count
    //////////////////////////////

    // One step per result bit, same for both operations
    localparam int iterCount = mcycleArithPkg::operandWidth;

    // Down-counter must hold iterCount itself
    localparam int iterCountWidth = $clog2(iterCount + 1);

    //////////////////////////////
    // Sequencer states
    //////////////////////////////

    typedef enum logic [1:0] {
        idle    = 2'd0,
        running = 2'd1,
        // Single Done cycle, a new Start may be taken here
        finish  = 2'd2
    } ctrlStateT;

    //////////////////////////////
    // Controller to datapath
    //////////////////////////////

    typedef struct packed {
        // Load operands and operation
        logic init;
        // One shift-add or shift-subtract step
        logic shift;
        // Keep the adder output in this step
        logic write;
    } stepCtrlT;

endpackage

//--- hdl/mcycleDatapath.sv
`timescale 1ns/100ps

module mcycleDatapath (
    input  logic                                    CLK,
    input  logic                                    Reset,
    input  mcycleArithPkg::mcycleReqT               Req,
    input  mcycleCtrlPkg::stepCtrlT                 Step,
    output logic                                    StepDecision,
    output logic [mcycleArithPkg::operandWidth-1:0] Result
);

    // Accumulator, upper half is the partial sum or partial remainder
    logic [mcycleArithPkg::accWidth-1:0] acc;

    // Multiplicand or divisor
    logic [mcycleArithPkg::operandWidth-1:0] opnd;

    mcycleArithPkg::mcycleOpT opReg;

    // One extra bit for the shifted remainder in divide
    logic [mcycleArithPkg::operandWidth:0]   addA;
    logic [mcycleArithPkg::operandWidth:0]   addB;
    logic                                    addCin;
    logic [mcycleArithPkg::operandWidth+1:0] addSum;

    logic isDiv;

    assign isDiv = (opReg == mcycleArithPkg::opDiv);

    //////////////////////////////
    // Adder
    //////////////////////////////

    always_comb begin
        if (isDiv) begin
            // Trial subtraction on the remainder shifted left by one
            addA = acc[mcycleArithPkg::accWidth-1:mcycleArithPkg::operandWidth-1];
            addB = ~{1'b0, opnd};
        end else begin
            addA = {1'b0, acc[mcycleArithPkg::accWidth-1:mcycleArithPkg::operandWidth]};
            addB = {1'b0, opnd};
        end
    end

    // Carry in completes the two's complement for subtraction
    assign addCin = isDiv;

    assign addSum = {1'b0, addA} + {1'b0, addB}
                  + {{(mcycleArithPkg::operandWidth + 1){1'b0}}, addCin};

    // Divide keeps the difference when there is no borrow,
    // multiply adds when the current multiplier bit is set
    assign StepDecision = isDiv ? addSum[mcycleArithPkg::operandWidth+1] : acc[0];

    //////////////////////////////
    // Accumulator and operation
    //////////////////////////////

    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            acc   <= '0;
            opReg <= mcycleArithPkg::opMul;
        end else if (Step.init) begin
            opReg <= Req.op;
            // Dividend or multiplier goes to the low half
            if (Req.op == mcycleArithPkg::opDiv) begin
                acc <= {{mcycleArithPkg::operandWidth{1'b0}}, Req.operand1};
            end else begin
                acc <= {{mcycleArithPkg::operandWidth{1'b0}}, Req.operand2};
            end
        end else if (Step.shift) begin
            if (isDiv) begin
                // Shift left, quotient bit enters at the bottom
                if (Step.write) begin
                    acc <= {addSum[mcycleArithPkg::operandWidth-1:0],
                            acc[mcycleArithPkg::operandWidth-2:0], 1'b1};
                end else begin
                    acc <= {acc[mcycleArithPkg::accWidth-2:0], 1'b0};
                end
            end else begin
                // Sum with its carry lands above the low half, then shift right
                if (Step.write) begin
                    acc <= {addSum[mcycleArithPkg::operandWidth:0],
                            acc[mcycleArithPkg::operandWidth-1:1]};
                end else begin
                    acc <= {1'b0, acc[mcycleArithPkg::accWidth-1:1]};
                end
            end
        end
    end

    // Operand register
    always_ff @(posedge CLK) begin
        if (Step.init) begin
            if (Req.op == mcycleArithPkg::opDiv) begin
                opnd <= Req.operand2;
            end else begin
                opnd <= Req.operand1;
            end
        end
    end

    // Low product word or quotient, held once stepping stops
    assign Result = acc[mcycleArithPkg::operandWidth-1:0];

    //////////////////////////////
    // Assertions
    //////////////////////////////

    opStableWhileStepping: assert property (
        @(posedge CLK) disable iff (Reset)
        Step.shift && $past(Step.shift) |-> $stable(opReg)
    ) else $error("Captured operation changed during stepping");

endmodule

//--- hdl/mcycleUnit.sv
`timescale 1ns/100ps

module mcycleUnit (
    input  logic                                    CLK,
    input  logic                                    Reset,
    input  logic                                    Start,
    input  mcycleArithPkg::mcycleReqT               Req,
    output logic [mcycleArithPkg::operandWidth-1:0] Result,
    output logic                                    Busy,
    output logic                                    Done
);

    //////////////////////////////
    // Internal links
    //////////////////////////////

    // Step strobes towards the datapath
    mcycleCtrlPkg::stepCtrlT step;

    // Add or keep-difference decision back to the controller
    logic stepDecision;

    //////////////////////////////
    // Sequencer
    //////////////////////////////

    mcycleControl control (
        .CLK          (CLK),
        .Reset        (Reset),
        .Start        (Start),
        .StepDecision (stepDecision),
        .Step         (step),
        .Busy         (Busy),
        .Done         (Done)
    );

    //////////////////////////////
    // Arithmetic
    //////////////////////////////

    mcycleDatapath datapath (
        .CLK          (CLK),
        .Reset        (Reset),
        .Req          (Req),
        .Step         (step),
        .StepDecision (stepDecision),
        .Result       (Result)
    );

endmodule

//--- sources.f
hdl/mcycleArithPkg.sv
hdl/mcycleCtrlPkg.sv
hdl/mcycleControl.sv
hdl/mcycleDatapath.sv
hdl/mcycleUnit.sv
tb/tbMcycleChecks.sv
tb/tbMcycle.sv

//--- tb/tbMcycle.sv
`timescale 1ns/100ps

module tbMcycle;

    // Every operation fits in iterCount + 3 cycles, plus reset
    localparam int cycleLimit = 60 * (mcycleCtrlPkg::iterCount + 3) + 20;

    logic                                    CLK;
    logic                                    Reset;
    logic                                    start;
    mcycleArithPkg::mcycleReqT               req;
    logic [mcycleArithPkg::operandWidth-1:0] result;
    logic                                    busy;
    logic                                    done;
    logic                                    checkFailed;

    int cycleCount = 0;
    int doneCount  = 0;
    int opsIssued  = 0;

    mcycleUnit uut (
        .CLK    (CLK),
        .Reset  (Reset),
        .Start  (start),
        .Req    (req),
        .Result (result),
        .Busy   (busy),
        .Done   (done)
    );

    tbMcycleChecks checks (
        .CLK    (CLK),
        .Reset  (Reset),
        .Start  (start),
        .Req    (req),
        .Result (result),
        .Busy   (busy),
        .Done   (done),
        .Failed (checkFailed)
    );

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    //////////////////////////////
    // Timeout and Done count
    //////////////////////////////

    always @(posedge CLK) begin
        cycleCount <= cycleCount + 1;
        if (!Reset && done) begin
            doneCount <= doneCount + 1;
        end
        if (cycleCount >= cycleLimit) begin
            $display("Run did not finish within %0d cycles", cycleLimit);
            $display("Test FAILED");
            $fatal(1, "Timeout");
        end
    end

    always @(posedge checkFailed) begin
        $display("Test FAILED");
        $fatal(1, "Stopped at the first failing check");
    end

    //////////////////////////////
    // Stimulus helpers
    //////////////////////////////

    // Called 1 ns after an edge, leaves 1 ns after the accepting edge
    task automatic startOp(input mcycleArithPkg::mcycleOpT op,
                           input logic [mcycleArithPkg::operandWidth-1:0] a,
                           input logic [mcycleArithPkg::operandWidth-1:0] b);
        start        = 1'b1;
        req.op       = op;
        req.operand1 = a;
        req.operand2 = b;
        @(posedge CLK);
        #1;
        start     = 1'b0;
        opsIssued = opsIssued + 1;
    endtask

    task automatic awaitDone();
        while (done !== 1'b1) begin
            @(posedge CLK);
            #1;
        end
    endtask

    task automatic idleCycles(input int n);
        repeat (n) begin
            @(posedge CLK);
            #1;
        end
    endtask

    task automatic runOp(input mcycleArithPkg::mcycleOpT op,
                         input logic [mcycleArithPkg::operandWidth-1:0] a,
                         input logic [mcycleArithPkg::operandWidth-1:0] b);
        startOp(op, a, b);
        awaitDone();
        idleCycles(1);
    endtask

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin
        logic [mcycleArithPkg::operandWidth-1:0] a;
        logic [mcycleArithPkg::operandWidth-1:0] b;
        mcycleArithPkg::mcycleOpT                op;

        void'($urandom(90336));
        Reset = 1'b1;
        start = 1'b0;
        req   = '0;
        repeat (2) @(posedge CLK);
        #1;
        Reset = 1'b0;
        idleCycles(3);

        // Directed multiply
        runOp(mcycleArithPkg::opMul, 32'h0000_0000, 32'hDEAD_BEEF);
        runOp(mcycleArithPkg::opMul, 32'h1234_5678, 32'h0000_0000);
        runOp(mcycleArithPkg::opMul, 32'h0000_0001, 32'hCAFE_F00D);
        runOp(mcycleArithPkg::opMul, 32'h89AB_CDEF, 32'h0000_0001);
        runOp(mcycleArithPkg::opMul, 32'hFFFF_FFFF, 32'hFFFF_FFFF);
        runOp(mcycleArithPkg::opMul, 32'h8000_0000, 32'h0000_0002);
        runOp(mcycleArithPkg::opMul, 32'h0001_0000, 32'h0001_0000);
        runOp(mcycleArithPkg::opMul, 32'h0000_0020, 32'h0F0F_0F0F);

        // Directed divide, zero divisor gives all ones
        runOp(mcycleArithPkg::opDiv, 32'h0000_0005, 32'h0000_0011);
        runOp(mcycleArithPkg::opDiv, 32'h0000_4242, 32'h0000_4242);
        runOp(mcycleArithPkg::opDiv, 32'hFEDC_BA98, 32'h0000_0001);
        runOp(mcycleArithPkg::opDiv, 32'h1234_5678, 32'h0000_0000);
        runOp(mcycleArithPkg::opDiv, 32'h0000_0000, 32'h0000_0007);
        runOp(mcycleArithPkg::opDiv, 32'hFFFF_FFFF, 32'h0000_0010);

        // Start while Busy must be ignored
        startOp(mcycleArithPkg::opMul, 32'h0001_2345, 32'h0006_789A);
        idleCycles(4);
        start        = 1'b1;
        req.op       = mcycleArithPkg::opDiv;
        req.operand1 = 32'h5555_5555;
        req.operand2 = 32'h0000_0003;
        idleCycles(1);
        start = 1'b0;
        awaitDone();
        idleCycles(1);

        // Back to back, second Start in the Done cycle
        startOp(mcycleArithPkg::opMul, 32'h0BAD_F00D, 32'h0000_1357);
        awaitDone();
        startOp(mcycleArithPkg::opDiv, 32'h7654_3210, 32'h0000_0123);
        awaitDone();
        idleCycles(1);

        // Random operands, some small or zero divisors
        repeat (30) begin
            op = ($urandom_range(0, 1) == 0) ? mcycleArithPkg::opMul : mcycleArithPkg::opDiv;
            a  = $urandom();
            b  = $urandom();
            if ($urandom_range(0, 7) == 0) begin
                b = '0;
            end else if ($urandom_range(0, 1) == 0) begin
                b = b >> $urandom_range(0, 31);
            end
            runOp(op, a, b);
            idleCycles($urandom_range(0, 2));
        end

        idleCycles(3);
        if (checkFailed === 1'b1 || doneCount != opsIssued) begin
            $display("Issued %0d operations but saw %0d Done pulses", opsIssued, doneCount);
            $display("Test FAILED");
            $fatal(1, "Operation count mismatch");
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

//--- tb/tbMcycleChecks.sv
`timescale 1ns/100ps

module tbMcycleChecks (
    input  logic                                    CLK,
    input  logic                                    Reset,
    input  logic                                    Start,
    input  mcycleArithPkg::mcycleReqT               Req,
    input  logic [mcycleArithPkg::operandWidth-1:0] Result,
    input  logic                                    Busy,
    input  logic                                    Done,
    output logic                                    Failed
);

    // Done is seen this many edges after the accepting edge
    localparam int doneDelay = mcycleCtrlPkg::iterCount + 1;

    mcycleArithPkg::mcycleReqT reqQ[$];

    logic [mcycleArithPkg::operandWidth-1:0] expectedResult;
    logic [mcycleArithPkg::operandWidth-1:0] heldResult;

    logic accepted;
    logic inFlight;
    logic holding;
    logic seenStart;
    int   cyclesSinceStart;
    int   pendingCount;

    event failSeen;

    //////////////////////////////
    // Reference arithmetic
    //////////////////////////////

    function automatic logic [mcycleArithPkg::operandWidth-1:0] refResult(
        input mcycleArithPkg::mcycleReqT r
    );
        if (r.op == mcycleArithPkg::opMul) begin
            // Only the low product word is visible
            return r.operand1 * r.operand2;
        end else if (r.operand2 == '0) begin
            return '1;
        end else begin
            return r.operand1 / r.operand2;
        end
    endfunction

    //////////////////////////////
    // Request tracking
    //////////////////////////////

    assign accepted = Start && !Busy;

    always @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            reqQ.delete();
            expectedResult   <= '0;
            heldResult       <= '0;
            inFlight         <= 1'b0;
            holding          <= 1'b0;
            seenStart        <= 1'b0;
            cyclesSinceStart <= 0;
            pendingCount     <= 0;
        end else begin
            // Retire before accepting so a Start in the Done cycle becomes the next request
            if (Done && reqQ.size() > 0) begin
                void'(reqQ.pop_front());
                heldResult <= expectedResult;
                holding    <= 1'b1;
                inFlight   <= 1'b0;
            end
            if (accepted) begin
                reqQ.push_back(Req);
                inFlight         <= 1'b1;
                holding          <= 1'b0;
                seenStart        <= 1'b1;
                cyclesSinceStart <= 1;
            end else if (inFlight) begin
                cyclesSinceStart <= cyclesSinceStart + 1;
            end
            // Expected value of the oldest request still in flight
            if (reqQ.size() > 0) begin
                expectedResult <= refResult(reqQ[0]);
            end
            pendingCount <= reqQ.size();
        end
    end

    always @(failSeen) begin
        Failed = 1'b1;
    end

    //////////////////////////////
    // Checks
    //////////////////////////////

    quietResult: assert property (
        @(posedge CLK) disable iff (Reset)
        !seenStart |-> Result == '0
    ) else begin
        $display("CHECK FAILED: Result expected %h actual %h after reset",
                 {mcycleArithPkg::operandWidth{1'b0}}, $sampled(Result));
        -> failSeen;
    end

    quietStrobes: assert property (
        @(posedge CLK) disable iff (Reset)
        !seenStart |-> !Busy && !Done
    ) else begin
        $display("Busy or Done went high before any Start was given");
        -> failSeen;
    end

    busyDuringSteps: assert property (
        @(posedge CLK) disable iff (Reset)
        inFlight && cyclesSinceStart < doneDelay |-> Busy && !Done
    ) else begin
        $display("Busy dropped or Done came early while the steps were running");
        -> failSeen;
    end

    doneOnTime: assert property (
        @(posedge CLK) disable iff (Reset)
        inFlight && cyclesSinceStart == doneDelay |-> Done && !Busy
    ) else begin
        $display("Done missing or Busy still high one cycle after the last step");
        -> failSeen;
    end

    doneMatchesStart: assert property (
        @(posedge CLK) disable iff (Reset)
        Done |-> inFlight && cyclesSinceStart == doneDelay && pendingCount == 1
    ) else begin
        $display("Done seen without a matching accepted Start");
        -> failSeen;
    end

    donePulse: assert property (
        @(posedge CLK) disable iff (Reset)
        Done |=> !Done
    ) else begin
        $display("Done stayed high for more than one cycle");
        -> failSeen;
    end

    resultAtDone: assert property (
        @(posedge CLK) disable iff (Reset)
        Done |-> Result == expectedResult
    ) else begin
        $display("CHECK FAILED: Result expected %h actual %h",
                 $sampled(expectedResult), $sampled(Result));
        -> failSeen;
    end

    resultHeld: assert property (
        @(posedge CLK) disable iff (Reset)
        holding |-> Result == heldResult
    ) else begin
        $display("CHECK FAILED: Result (held) expected %h actual %h",
                 $sampled(heldResult), $sampled(Result));
        -> failSeen;
    end

endmodule
